// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary -j 0
TOP      = tart_tb
FILELIST = tart_top.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -qx "No errors" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(TOOL) --lint-only -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== include/tart_defines.svh ====
`ifndef TART_DEFINES_SVH
`define TART_DEFINES_SVH

// --------------------
// Widths
// --------------------
`define TART_DATA_BITS    8   // Register bus data
`define TART_ADR_BITS     7   // Register bus address
`define TART_ANT_BITS     8   // Antenna word, same as bus data
`define TART_DELAY_BITS   3   // Sample delay, taps 0..7
`define TART_COUNT_BITS   16  // Sample counter and checksum

// --------------------
// Address groups
// --------------------
`define TART_ACQ_GROUP    0   // adr[6:4]
`define TART_CTL_GROUP    15  // adr[6:3]

// Control group registers
`define TART_REG_STATUS   0
`define TART_REG_RESET    1
`define TART_REG_SCRATCH  2

// Acquire group registers
`define TART_REG_CTRL     0   // enable, debug, delay
`define TART_REG_COUNT_LO 1
`define TART_REG_COUNT_HI 2
`define TART_REG_SUM_LO   3
`define TART_REG_SUM_HI   4

`define TART_RESET_CYCLES 4   // Soft-reset pulse length

`endif

// ==== logic/tart_acquire.sv ====
`timescale 1ns/100ps

`include "tart_defines.svh"

// Acquisition settings and capture read-back
module tart_acquire (
   input  logic                        b_clk,
   input  logic                        aq_reset_i,  // Host reset or soft reset

   // Register port
   input  logic                        stb_i,
   input  logic                        we_i,
   input  tart_pkg::bus_adr_t          adr_i,
   input  logic [`TART_DATA_BITS-1:0]  dat_i,
   output logic [`TART_DATA_BITS-1:0]  dat_o,
   output logic                        ack_o,

   // Settings to capture
   output logic                        aq_enable_o,
   output logic                        aq_debug_o,
   output logic [`TART_DELAY_BITS-1:0] aq_delay_o,

   // Results from capture
   input  logic [`TART_COUNT_BITS-1:0] sample_count_i,
   input  logic [`TART_COUNT_BITS-1:0] checksum_i
);

   localparam int IBITS = `TART_ADR_BITS - 3;   // Acquire view index
   localparam int CTRLZ = `TART_DATA_BITS - 2 - `TART_DELAY_BITS;

   logic                       req;
   logic                       wr;
   logic [IBITS-1:0]           idx;
   logic [`TART_DATA_BITS-1:0] rd_dat;

   assign req = stb_i & ~ack_o;
   assign wr  = req & we_i;
   assign idx = adr_i.acq.index;

   always_ff @(posedge b_clk) begin
      if (aq_reset_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= req;          // Also acks writes to read-only regs
      end
   end

   // --------------------
   // CTRL register
   // --------------------
   // Same bit layout as the low bits of STATUS
   always_ff @(posedge b_clk) begin
      if (aq_reset_i) begin
         aq_enable_o <= 1'b0;
         aq_debug_o  <= 1'b0;
         aq_delay_o  <= '0;
      end else if (wr && idx == IBITS'(`TART_REG_CTRL)) begin
         aq_enable_o <= dat_i[0];
         aq_debug_o  <= dat_i[1];
         aq_delay_o  <= dat_i[`TART_DELAY_BITS+1:2];
      end
   end

   // --------------------
   // Read back
   // --------------------
   always_comb begin
      case (idx)
         IBITS'(`TART_REG_CTRL):     rd_dat = {{CTRLZ{1'b0}}, aq_delay_o,
                                               aq_debug_o, aq_enable_o};
         IBITS'(`TART_REG_COUNT_LO): rd_dat = sample_count_i[`TART_DATA_BITS-1:0];
         IBITS'(`TART_REG_COUNT_HI): rd_dat = sample_count_i[`TART_COUNT_BITS-1:
                                                             `TART_DATA_BITS];
         IBITS'(`TART_REG_SUM_LO):   rd_dat = checksum_i[`TART_DATA_BITS-1:0];
         IBITS'(`TART_REG_SUM_HI):   rd_dat = checksum_i[`TART_COUNT_BITS-1:
                                                         `TART_DATA_BITS];
         default:                    rd_dat = '0;
      endcase
   end

   always_ff @(posedge b_clk) begin
      if (req) begin
         dat_o <= rd_dat;       // Held through the ack cycle
      end
   end

endmodule

// ==== logic/tart_bus.sv ====
`timescale 1ns/100ps

`include "tart_defines.svh"

// Register bus decoder between the host port and the two register blocks
module tart_bus (
   input  logic                       b_clk,
   input  logic                       reset_i,

   // Host side, Wishbone classic
   input  logic                       cyc_i,
   input  logic                       stb_i,
   input  tart_pkg::bus_adr_t         adr_i,
   output logic [`TART_DATA_BITS-1:0] dat_o,
   output logic                       ack_o,

   // Device side
   output logic                       ctl_stb_o,
   output logic                       acq_stb_o,
   input  logic                       ctl_ack_i,
   input  logic                       acq_ack_i,
   input  logic [`TART_DATA_BITS-1:0] ctl_dat_i,
   input  logic [`TART_DATA_BITS-1:0] acq_dat_i
);

   logic req;      // Live request from the master
   logic ctl_hit;
   logic acq_hit;
   logic nul_stb;  // Request to nowhere
   logic ctl_sel;  // Held until ack
   logic acq_sel;
   logic nul_ack;

   // --------------------
   // Decode
   // --------------------
   assign req     = cyc_i & stb_i;
   assign ctl_hit = adr_i.ctl.group == 4'(`TART_CTL_GROUP);
   assign acq_hit = adr_i.acq.group == 3'(`TART_ACQ_GROUP);

   assign ctl_stb_o = req & ctl_hit;
   assign acq_stb_o = req & acq_hit;
   assign nul_stb   = req & ~ctl_hit & ~acq_hit;

   // --------------------
   // Select hold
   // --------------------
   // Set by the strobe, cleared by the device ack or by cyc going away
   always_ff @(posedge b_clk) begin
      if (reset_i || !cyc_i) begin
         ctl_sel <= 1'b0;
         acq_sel <= 1'b0;
      end else begin
         ctl_sel <= ctl_ack_i ? 1'b0 : ctl_sel | ctl_stb_o;
         acq_sel <= acq_ack_i ? 1'b0 : acq_sel | acq_stb_o;
      end
   end

   // Fallback ack so an unmapped access cannot hang the bus
   always_ff @(posedge b_clk) begin
      if (reset_i) begin
         nul_ack <= 1'b0;
      end else begin
         nul_ack <= nul_stb & ~nul_ack; // One cycle only, stb is still up
      end
   end

   // --------------------
   // Return path
   // --------------------
   // Stray acks from a dropped cycle are ignored
   assign ack_o = (ctl_sel & ctl_ack_i) | (acq_sel & acq_ack_i) | nul_ack;

   always_comb begin
      if (ctl_sel) begin
         dat_o = ctl_dat_i;
      end else if (acq_sel) begin
         dat_o = acq_dat_i;
      end else begin
         dat_o = '0;            // Unmapped reads as zero
      end
   end

endmodule

// ==== logic/tart_capture.sv ====
`timescale 1ns/100ps

`include "tart_defines.svh"

// Antenna sampling with a selectable delay, sample counter and checksum
module tart_capture (
   input  logic                        b_clk,
   input  logic                        aq_reset_i,

   input  logic                        enable_i,
   input  logic                        debug_i,    // Count replaces antenna
   input  logic [`TART_DELAY_BITS-1:0] delay_i,
   input  logic [`TART_ANT_BITS-1:0]   antenna_i,

   output logic [`TART_COUNT_BITS-1:0] sample_count_o,
   output logic [`TART_COUNT_BITS-1:0] checksum_o
);

   localparam int TAPS = 1 << `TART_DELAY_BITS;  // Eight taps, 0 is undelayed
   localparam int XBITS = `TART_COUNT_BITS - `TART_ANT_BITS;

   logic                                en_q;    // Enable edge detect
   logic                                start;
   logic                                step;
   logic [`TART_ANT_BITS-1:0]           src;
   logic [TAPS-2:0][`TART_ANT_BITS-1:0] line_q;  // Older samples
   logic [TAPS-1:0][`TART_ANT_BITS-1:0] taps;
   logic [`TART_ANT_BITS-1:0]           tap;

   assign start = enable_i & ~en_q;   // First enabled cycle only clears
   assign step  = enable_i & en_q;

   // Debug source is the low byte of the count
   assign src = debug_i ? sample_count_o[`TART_ANT_BITS-1:0] : antenna_i;

   // taps[d] is the sample from d enabled cycles back
   assign taps = {line_q, src};
   assign tap  = taps[delay_i];

   always_ff @(posedge b_clk) begin
      if (aq_reset_i) begin
         en_q <= 1'b0;
      end else begin
         en_q <= enable_i;
      end
   end

   // --------------------
   // Delay line
   // --------------------
   // Cleared on start, so early taps read zero
   always_ff @(posedge b_clk) begin
      if (start) begin
         line_q <= '0;
      end else if (step) begin
         line_q <= taps[TAPS-2:0];  // Shift by one
      end
   end

   // --------------------
   // Count and checksum
   // --------------------
   always_ff @(posedge b_clk) begin
      if (aq_reset_i || start) begin
         sample_count_o <= '0;
         checksum_o     <= '0;
      end else if (step) begin
         sample_count_o <= sample_count_o + 1'b1;
         checksum_o     <= checksum_o + {{XBITS{1'b0}}, tap}; // Wraps at 2^16
      end
   end

endmodule

// ==== logic/tart_control.sv ====
`timescale 1ns/100ps

`include "tart_defines.svh"

// Status, scratch and soft-reset registers
module tart_control (
   input  logic                       b_clk,
   input  logic                       reset_i,

   // Register port
   input  logic                       stb_i,
   input  logic                       we_i,
   input  tart_pkg::bus_adr_t         adr_i,
   input  logic [`TART_DATA_BITS-1:0] dat_i,
   output logic [`TART_DATA_BITS-1:0] dat_o,
   output logic                       ack_o,

   input  logic [`TART_DATA_BITS-1:0] status_i,     // Assembled at top level
   output logic                       soft_reset_o  // To acquisition side
);

   localparam int IBITS = `TART_ADR_BITS - 4;                 // Control view index
   localparam int RBITS = $clog2(`TART_RESET_CYCLES + 1);

   logic                       req;        // New access, ack not yet given
   logic                       wr;
   logic [IBITS-1:0]           idx;
   logic [`TART_DATA_BITS-1:0] scratch_q;
   logic [`TART_DATA_BITS-1:0] rd_dat;
   logic                       reset_req;  // Set in the ack cycle of a reset write
   logic [RBITS-1:0]           reset_cnt;

   assign req = stb_i & ~ack_o;
   assign wr  = req & we_i;
   assign idx = adr_i.ctl.index;

   // Single-cycle ack, one clock after the strobe
   always_ff @(posedge b_clk) begin
      if (reset_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= req;
      end
   end

   always_ff @(posedge b_clk) begin
      if (wr && idx == IBITS'(`TART_REG_SCRATCH)) begin
         scratch_q <= dat_i;
      end
   end

   // --------------------
   // Soft reset
   // --------------------
   // Pulse starts the cycle after the ack, runs for the full count
   always_ff @(posedge b_clk) begin
      if (reset_i) begin
         reset_req <= 1'b0;
         reset_cnt <= '0;
      end else begin
         reset_req <= wr && idx == IBITS'(`TART_REG_RESET) && dat_i[0];
         if (reset_req) begin
            reset_cnt <= RBITS'(`TART_RESET_CYCLES);
         end else if (reset_cnt != '0) begin
            reset_cnt <= reset_cnt - 1'b1;              // Count down to idle
         end
      end
   end

   assign soft_reset_o = reset_cnt != '0;

   // --------------------
   // Read back
   // --------------------
   always_comb begin
      case (idx)
         IBITS'(`TART_REG_STATUS):  rd_dat = status_i;
         IBITS'(`TART_REG_RESET):   rd_dat = {{(`TART_DATA_BITS-1){1'b0}},
                                              soft_reset_o | reset_req}; // Busy flag
         IBITS'(`TART_REG_SCRATCH): rd_dat = scratch_q;
         default:                   rd_dat = '0;
      endcase
   end

   // Captured with the request, valid in the ack cycle
   always_ff @(posedge b_clk) begin
      if (req) begin
         dat_o <= rd_dat;
      end
   end

endmodule

// ==== logic/tart_pkg.sv ====
package tart_pkg;

`include "tart_defines.svh"

   // One bus address, two decodes
   // Acquire block splits it 3/4, control block 4/3
   typedef union packed {
      // Acquire view
      struct packed {
         logic [2:0]                group; // adr[6:4]
         logic [`TART_ADR_BITS-4:0] index; // adr[3:0], up to 16 regs
      } acq;

      // Control view, lives at the top of the map
      struct packed {
         logic [3:0]                group; // adr[6:3]
         logic [`TART_ADR_BITS-5:0] index; // adr[2:0], up to 8 regs
      } ctl;
   } bus_adr_t;

endpackage

// ==== logic/tart_top.sv ====
`timescale 1ns/100ps

`include "tart_defines.svh"

// Register bus of the acquisition front end
module tart_top (
   input  logic                       b_clk,
   input  logic                       reset_i,

   // Host Wishbone port
   input  logic                       wb_cyc_i,
   input  logic                       wb_stb_i,
   input  logic                       wb_we_i,
   input  logic [`TART_ADR_BITS-1:0]  wb_adr_i,
   input  logic [`TART_DATA_BITS-1:0] wb_dat_i,
   output logic [`TART_DATA_BITS-1:0] wb_dat_o,
   output logic                       wb_ack_o,

   input  logic [`TART_ANT_BITS-1:0]  antenna_i
);

   localparam int STATZ = `TART_DATA_BITS - 3 - `TART_DELAY_BITS;

   tart_pkg::bus_adr_t          bus_adr;

   // Device strobes and returns
   logic                        ctl_stb;
   logic                        acq_stb;
   logic                        ctl_ack;
   logic                        acq_ack;
   logic [`TART_DATA_BITS-1:0]  ctl_dat;
   logic [`TART_DATA_BITS-1:0]  acq_dat;

   // Acquisition side
   logic                        soft_reset;
   logic                        aq_reset;
   logic                        aq_enable;
   logic                        aq_debug;
   logic [`TART_DELAY_BITS-1:0] aq_delay;
   logic [`TART_COUNT_BITS-1:0] sample_count;
   logic [`TART_COUNT_BITS-1:0] checksum;
   logic [`TART_DATA_BITS-1:0]  status;

   assign bus_adr  = wb_adr_i;
   assign aq_reset = reset_i | soft_reset;  // Host reset or pulse from control

   // Status byte, zeros above the reset flag
   assign status = {{STATZ{1'b0}}, soft_reset, aq_delay, aq_debug, aq_enable};

   // --------------------
   // Bus and registers
   // --------------------
   tart_bus TART_BUS0 (
      .b_clk     (b_clk),
      .reset_i   (reset_i),
      .cyc_i     (wb_cyc_i),
      .stb_i     (wb_stb_i),
      .adr_i     (bus_adr),
      .dat_o     (wb_dat_o),
      .ack_o     (wb_ack_o),
      .ctl_stb_o (ctl_stb),
      .acq_stb_o (acq_stb),
      .ctl_ack_i (ctl_ack),
      .acq_ack_i (acq_ack),
      .ctl_dat_i (ctl_dat),
      .acq_dat_i (acq_dat)
   );

   tart_control TART_CONTROL0 (
      .b_clk        (b_clk),
      .reset_i      (reset_i),
      .stb_i        (ctl_stb),
      .we_i         (wb_we_i),
      .adr_i        (bus_adr),
      .dat_i        (wb_dat_i),
      .dat_o        (ctl_dat),
      .ack_o        (ctl_ack),
      .status_i     (status),
      .soft_reset_o (soft_reset)
   );

   tart_acquire TART_ACQUIRE0 (
      .b_clk          (b_clk),
      .aq_reset_i     (aq_reset),
      .stb_i          (acq_stb),
      .we_i           (wb_we_i),
      .adr_i          (bus_adr),
      .dat_i          (wb_dat_i),
      .dat_o          (acq_dat),
      .ack_o          (acq_ack),
      .aq_enable_o    (aq_enable),
      .aq_debug_o     (aq_debug),
      .aq_delay_o     (aq_delay),
      .sample_count_i (sample_count),
      .checksum_i     (checksum)
   );

   // --------------------
   // Capture
   // --------------------
   tart_capture TART_CAPTURE0 (
      .b_clk          (b_clk),
      .aq_reset_i     (aq_reset),
      .enable_i       (aq_enable),
      .debug_i        (aq_debug),
      .delay_i        (aq_delay),
      .antenna_i      (antenna_i),
      .sample_count_o (sample_count),
      .checksum_o     (checksum)
   );

endmodule

// ==== tart_top.f ====
+incdir+include
logic/tart_pkg.sv
logic/tart_bus.sv
logic/tart_control.sv
logic/tart_acquire.sv
logic/tart_capture.sv
logic/tart_top.sv
verif/tart_tb.sv

// ==== verif/tart_tb.sv ====
`timescale 1ns/100ps

`include "tart_defines.svh"

module tart_tb;

   // Register addresses with the group code in the upper bits
   localparam logic [6:0] ACQ_BASE    = 7'(`TART_ACQ_GROUP << 4);
   localparam logic [6:0] CTL_BASE    = 7'(`TART_CTL_GROUP << 3);
   localparam logic [6:0] ADR_CTRL    = ACQ_BASE + 7'(`TART_REG_CTRL);
   localparam logic [6:0] ADR_CNT_LO  = ACQ_BASE + 7'(`TART_REG_COUNT_LO);
   localparam logic [6:0] ADR_CNT_HI  = ACQ_BASE + 7'(`TART_REG_COUNT_HI);
   localparam logic [6:0] ADR_SUM_LO  = ACQ_BASE + 7'(`TART_REG_SUM_LO);
   localparam logic [6:0] ADR_SUM_HI  = ACQ_BASE + 7'(`TART_REG_SUM_HI);
   localparam logic [6:0] ADR_STATUS  = CTL_BASE + 7'(`TART_REG_STATUS);
   localparam logic [6:0] ADR_RESET   = CTL_BASE + 7'(`TART_REG_RESET);
   localparam logic [6:0] ADR_SCRATCH = CTL_BASE + 7'(`TART_REG_SCRATCH);
   localparam logic [6:0] ADR_UNMAP   = 7'h20;   // Neither group
   localparam int         ACK_LIMIT   = 20;

   logic       b_clk;
   logic       reset;
   logic       wb_cyc;
   logic       wb_stb;
   logic       wb_we;
   logic [6:0] wb_adr;
   logic [7:0] wb_dat_w;
   logic [7:0] wb_dat_r;
   logic       wb_ack;
   logic [7:0] antenna;

   int          errors;
   logic [31:0] rng;

   tart_top DUT (
      .b_clk     (b_clk),
      .reset_i   (reset),
      .wb_cyc_i  (wb_cyc),
      .wb_stb_i  (wb_stb),
      .wb_we_i   (wb_we),
      .wb_adr_i  (wb_adr),
      .wb_dat_i  (wb_dat_w),
      .wb_dat_o  (wb_dat_r),
      .wb_ack_o  (wb_ack),
      .antenna_i (antenna)
   );

   always #2 b_clk = ~b_clk;   // 4 ns period

   // --------------------
   // Helpers
   // --------------------
   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Checksum of a capture run with a constant antenna word
   function automatic logic [15:0] expected_sum(input int count, input int delay,
                                                input logic debug, input logic [7:0] ant);
      logic [15:0] sum;
      logic [7:0]  sample;
      sum = 16'h0000;
      for (int k = 0; k < count; k++) begin
         if (k >= delay) begin                     // Earlier taps read zero
            sample = debug ? 8'((k - delay) % 256) : ant;
            sum    = sum + {8'h00, sample};        // Wraps at 2^16
         end
      end
      return sum;
   endfunction

   task automatic check_value(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
      if (expected !== actual) begin
         $display("FAILED %s expected %h actual %h", name, expected, actual);
         errors++;
      end
   endtask

   // One Wishbone classic cycle with ack sampled on the falling edge
   task automatic bus_access(input logic we, input logic [6:0] adr,
                             input logic [7:0] wdat, output logic [15:0] rdat);
      logic got;
      got  = 1'b0;
      rdat = 16'h0000;
      @(posedge b_clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr;
      wb_dat_w <= wdat;
      for (int n = 0; n < ACK_LIMIT && !got; n++) begin
         @(negedge b_clk);
         if (wb_ack) begin
            got  = 1'b1;
            rdat = {8'h00, wb_dat_r};
         end
      end
      if (!got) begin
         $display("No ack from address %h within %0d cycles", adr, ACK_LIMIT);
         errors++;
      end
      @(posedge b_clk);
      wb_cyc <= 1'b0;                              // End of cycle
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic bus_write(input logic [6:0] adr, input logic [7:0] wdat);
      logic [15:0] unused;
      bus_access(1'b1, adr, wdat, unused);
   endtask

   task automatic bus_read(input logic [6:0] adr, output logic [15:0] rdat);
      bus_access(1'b0, adr, 8'h00, rdat);
   endtask

   task automatic read_word(input logic [6:0] lo_adr, input logic [6:0] hi_adr,
                            output logic [15:0] word);
      logic [15:0] lo;
      logic [15:0] hi;
      bus_read(lo_adr, lo);
      bus_read(hi_adr, hi);
      word = {hi[7:0], lo[7:0]};
   endtask

   // Run the capture with a fixed antenna word and check the checksum
   task automatic capture_run(input string name, input logic debug,
                              input logic [2:0] delay, input logic [7:0] ant);
      logic [15:0] count;
      logic [15:0] sum;
      int          hold;
      rng  = lcg_next(rng);
      hold = 20 + int'(rng[20:16]);
      @(posedge b_clk);
      antenna <= ant;
      bus_write(ADR_CTRL, {3'b000, delay, debug, 1'b0});
      bus_write(ADR_CTRL, {3'b000, delay, debug, 1'b1});   // Rising enable clears
      repeat (hold) @(posedge b_clk);
      bus_write(ADR_CTRL, {3'b000, delay, debug, 1'b0});   // Freeze
      read_word(ADR_CNT_LO, ADR_CNT_HI, count);
      read_word(ADR_SUM_LO, ADR_SUM_HI, sum);
      if (count == 16'h0000) begin
         $display("Capture run %s counted no samples", name);
         errors++;
      end
      check_value(name, expected_sum(int'(count), int'(delay), debug, ant), sum);
   endtask

   // --------------------
   // Tests
   // --------------------
   initial begin
      logic [15:0] rd;
      logic [15:0] word;
      logic [7:0]  val;
      logic [4:0]  ctrl;
      int          polls;

      b_clk    = 1'b0;
      reset    = 1'b1;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = 7'h00;
      wb_dat_w = 8'h00;
      antenna  = 8'h00;
      errors   = 0;
      rng      = 32'hc1a5_8390;
      repeat (10) @(posedge b_clk);
      reset <= 1'b0;

      // Reset values
      bus_read(ADR_CTRL, rd);
      check_value("reset ctrl", 16'h0000, rd);
      read_word(ADR_CNT_LO, ADR_CNT_HI, word);
      check_value("reset count", 16'h0000, word);
      read_word(ADR_SUM_LO, ADR_SUM_HI, word);
      check_value("reset sum", 16'h0000, word);
      bus_read(ADR_STATUS, rd);
      check_value("reset status", 16'h0000, rd);

      // Scratch and unmapped
      for (int i = 0; i < 4; i++) begin
         rng = lcg_next(rng);
         val = rng[23:16];
         bus_write(ADR_SCRATCH, val);
         bus_read(ADR_SCRATCH, rd);
         check_value("scratch", {8'h00, val}, rd);
      end
      bus_write(ADR_UNMAP, 8'hff);
      bus_read(ADR_UNMAP, rd);
      check_value("unmapped", 16'h0000, rd);

      // Normal mode with LCG antenna word and delay
      for (int i = 0; i < 4; i++) begin
         rng = lcg_next(rng);
         capture_run("normal sum", 1'b0, rng[26:24], rng[15:8]);
      end

      // Debug mode with the count as the source
      capture_run("debug sum d0", 1'b1, 3'd0, 8'h00);
      capture_run("debug sum d3", 1'b1, 3'd3, 8'h00);
      capture_run("debug sum d7", 1'b1, 3'd7, 8'h00);

      // CTRL mirrored into STATUS
      rng  = lcg_next(rng);
      ctrl = rng[20:16];
      bus_write(ADR_CTRL, {3'b000, ctrl});
      bus_read(ADR_STATUS, rd);
      check_value("status mirror", {11'h000, ctrl}, rd);
      bus_read(ADR_CTRL, rd);
      check_value("ctrl readback", {11'h000, ctrl}, rd);

      // Soft reset clears acquisition but keeps scratch
      rng = lcg_next(rng);
      val = rng[31:24];
      bus_write(ADR_SCRATCH, val);
      bus_write(ADR_CTRL, 8'h03);                  // Debug capture running
      repeat (12) @(posedge b_clk);
      bus_write(ADR_RESET, 8'h01);
      bus_read(ADR_RESET, rd);
      check_value("reset busy", 16'h0001, rd);
      polls = 0;
      while (rd != 16'h0000 && polls < ACK_LIMIT) begin
         bus_read(ADR_RESET, rd);
         polls++;
      end
      if (rd != 16'h0000) begin
         $display("Soft reset still busy after %0d polls", ACK_LIMIT);
         errors++;
      end
      bus_read(ADR_CTRL, rd);
      check_value("soft reset ctrl", 16'h0000, rd);
      read_word(ADR_CNT_LO, ADR_CNT_HI, word);
      check_value("soft reset count", 16'h0000, word);
      read_word(ADR_SUM_LO, ADR_SUM_HI, word);
      check_value("soft reset sum", 16'h0000, word);
      bus_read(ADR_SCRATCH, rd);
      check_value("soft reset scratch", {8'h00, val}, rd);

      $display("Run complete with %0d errors", errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule
